// ==== flist.f ====
+incdir+hw
+incdir+test
hw/fir_pkg.sv
hw/shift_reg.sv
hw/phase_splitter.sv
hw/fir_filter.sv
hw/decim_combiner.sv
hw/poly_decim_top.sv
test/tb_poly_decim.sv

// ==== hw/decim_combiner.sv ====
// Combiner for the two FIR branches. It sums, rounds half up, shifts
// down to sample width and saturates with a flag.
`timescale 1ns/100ps
`include "fir_cfg.svh"

module decim_combiner import fir_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       en_i,
    input  bsum_beat_t even_i,
    input  bsum_beat_t odd_i,
    output out_beat_t  out_o
);

    localparam int SUM_W = $bits(bsum_t) + 1;
    localparam logic signed [SUM_W-1:0] HALF  = SUM_W'(1) <<< (`FIR_ROUND_SHIFT - 1);
    localparam logic signed [SUM_W-1:0] S_MAX = SUM_W'(2 ** (`FIR_DATA_WIDTH - 1) - 1);
    localparam logic signed [SUM_W-1:0] S_MIN = -SUM_W'(2 ** (`FIR_DATA_WIDTH - 1));

    logic signed [SUM_W-1:0] total;
    logic signed [SUM_W-1:0] scaled;
    logic                    valid_q;
    logic                    sat_q;
    sample_t                 data_q;

    assign total  = even_i.sum + odd_i.sum + HALF;
    assign scaled = total >>> `FIR_ROUND_SHIFT;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= even_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            sat_q <= (scaled > S_MAX) || (scaled < S_MIN);
            if (scaled > S_MAX) begin
                data_q <= S_MAX[`FIR_DATA_WIDTH-1:0];
            end else if (scaled < S_MIN) begin
                data_q <= S_MIN[`FIR_DATA_WIDTH-1:0];
            end else begin
                data_q <= scaled[`FIR_DATA_WIDTH-1:0];
            end
        end
    end

    assign out_o.valid = valid_q && en_i;
    assign out_o.sat   = sat_q;
    assign out_o.data  = data_q;

    // Both branches share one strobe and one pipeline depth.
    a_branches_aligned: assert property (
        @(posedge clk_i) disable iff (!rstn_i) even_i.valid == odd_i.valid
    );

endmodule

// ==== hw/fir_cfg.svh ====
// Configuration macros for the polyphase decimate-by-two FIR.
// Sample and coefficient widths, tree depth, rounding shift and
// the 28-tap coefficient set split into even and odd halves.
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

`define FIR_DATA_WIDTH   16
`define FIR_COEF_WIDTH   18
`define FIR_BRANCH_TAPS  14
`define FIR_TREE_LEVELS  4
`define FIR_ROUND_SHIFT  15

// h[0], h[2], ..., h[26] of the full filter.
`define FIR_COEF_EVEN '{ \
    560, -120, -34, 40, -250, 412, -704, \
    1014, -1436, 1936, -2608, 3572, -5354, 11198}

// h[1], h[3], ..., h[27] of the full filter.
`define FIR_COEF_ODD '{ \
    608, -354, 538, -560, 692, -710, 740, \
    -662, 514, -198, -354, 1438, -4176, 27938}

`endif

// ==== hw/fir_filter.sv ====
// One polyphase FIR branch with a tapped delay line, registered multipliers
// and a registered pairwise adder tree padded with zero leaves.
`timescale 1ns/100ps
`include "fir_cfg.svh"

module fir_filter import fir_pkg::*; #(
    parameter coef_t COEF [`FIR_BRANCH_TAPS] = `FIR_COEF_EVEN
) (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    en_i,
    input  logic    valid_i,
    input  sample_t data_i,
    output logic    valid_o,
    output bsum_t   sum_o
);

    localparam int TAPS   = `FIR_BRANCH_TAPS;
    localparam int LEVELS = `FIR_TREE_LEVELS;
    localparam int LEAVES = 1 << LEVELS;
    localparam int NODES  = LEAVES - 1;

    sample_t taps_q [TAPS];
    prod_t   prod_q [TAPS];
    bsum_t   leaf   [LEAVES];
    // Tree nodes stored level by level, with the root last.
    bsum_t   node_q [NODES];

    // Delay line, multiply and four tree levels give six cycles.
    shift_reg #(
        .DELAY(2 + LEVELS)
    ) u_valid_dly (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .en_i  (en_i),
        .data_i(valid_i),
        .data_o(valid_o)
    );

    for (genvar t = 0; t < TAPS; t++) begin : g_tap
        if (t == 0) begin : g_head
            always_ff @(posedge clk_i) begin
                if (en_i && valid_i) begin
                    taps_q[t] <= data_i;
                end
            end
        end else begin : g_body
            always_ff @(posedge clk_i) begin
                if (en_i && valid_i) begin
                    taps_q[t] <= taps_q[t-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (en_i) begin
                prod_q[t] <= taps_q[t] * COEF[t];
            end
        end
    end

    for (genvar l = 0; l < LEAVES; l++) begin : g_leaf
        if (l < TAPS) begin : g_used
            assign leaf[l] = prod_q[l];
        end else begin : g_pad
            assign leaf[l] = '0;
        end
    end

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        localparam int BASE = LEAVES - (LEAVES >> lvl);
        for (genvar n = 0; n < (LEAVES >> (lvl + 1)); n++) begin : g_node
            if (lvl == 0) begin : g_first
                always_ff @(posedge clk_i) begin
                    if (en_i) begin
                        node_q[BASE+n] <= leaf[2*n] + leaf[2*n+1];
                    end
                end
            end else begin : g_next
                localparam int PREV = LEAVES - (LEAVES >> (lvl - 1));
                always_ff @(posedge clk_i) begin
                    if (en_i) begin
                        node_q[BASE+n] <= node_q[PREV+2*n] + node_q[PREV+2*n+1];
                    end
                end
            end
        end
    end

    assign sum_o = node_q[NODES-1];

    a_quiet_when_disabled: assert property (
        @(posedge clk_i) disable iff (!rstn_i) !en_i |-> !valid_o
    );

endmodule

// ==== hw/fir_pkg.sv ====
// Shared types for the decimating FIR. Sample, coefficient, product
// and branch-sum words, plus the beat structs passed between stages.
`include "fir_cfg.svh"

package fir_pkg;

    typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;
    typedef logic signed [`FIR_COEF_WIDTH-1:0] coef_t;
    typedef logic signed [`FIR_DATA_WIDTH+`FIR_COEF_WIDTH-1:0] prod_t;

    // Four guard bits cover the 16-leaf adder tree.
    typedef logic signed [`FIR_DATA_WIDTH+`FIR_COEF_WIDTH+3:0] bsum_t;

    typedef struct packed {
        logic    valid;
        sample_t odd;
        sample_t even;
    } pair_beat_t;

    typedef struct packed {
        logic  valid;
        bsum_t sum;
    } bsum_beat_t;

    typedef struct packed {
        logic    valid;
        logic    sat;
        sample_t data;
    } out_beat_t;

endpackage

// ==== hw/phase_splitter.sv ====
// Phase splitter that pairs consecutive input samples.
// The older sample goes out as the even half, the newer as the odd half.
`timescale 1ns/100ps

module phase_splitter import fir_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       en_i,
    input  logic       valid_i,
    input  sample_t    data_i,
    output pair_beat_t pair_o
);

    logic    accept;
    logic    phase_q;
    logic    strobe_q;
    sample_t even_q;
    sample_t odd_q;

    assign accept = en_i && valid_i;

    // Phase low means the next accepted sample is even-indexed.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            phase_q  <= 1'b0;
            strobe_q <= 1'b0;
        end else if (en_i) begin
            strobe_q <= valid_i && phase_q;
            if (valid_i) begin
                phase_q <= !phase_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            if (phase_q) begin
                odd_q <= data_i;
            end else begin
                even_q <= data_i;
            end
        end
    end

    // even_q cannot change before the branches have taken the pair.
    assign pair_o.valid = strobe_q && en_i;
    assign pair_o.odd   = odd_q;
    assign pair_o.even  = even_q;

    a_no_back_to_back: assert property (
        @(posedge clk_i) disable iff (!rstn_i) pair_o.valid |=> !pair_o.valid
    );

endmodule

// ==== hw/poly_decim_top.sv ====
// Top level of the decimate-by-two polyphase low-pass filter.
// Splitter feeds two 14-tap branches whose sums meet in the combiner.
`timescale 1ns/100ps
`include "fir_cfg.svh"

module poly_decim_top import fir_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      en_i,
    input  logic      valid_i,
    input  sample_t   data_i,
    output out_beat_t out_o
);

    pair_beat_t pair;
    bsum_beat_t even_beat;
    bsum_beat_t odd_beat;

    phase_splitter u_splitter (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .en_i   (en_i),
        .valid_i(valid_i),
        .data_i (data_i),
        .pair_o (pair)
    );

    // Even coefficients multiply the newer, odd-indexed sample.
    fir_filter #(
        .COEF(`FIR_COEF_EVEN)
    ) u_branch_even (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .en_i   (en_i),
        .valid_i(pair.valid),
        .data_i (pair.odd),
        .valid_o(even_beat.valid),
        .sum_o  (even_beat.sum)
    );

    fir_filter #(
        .COEF(`FIR_COEF_ODD)
    ) u_branch_odd (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .en_i   (en_i),
        .valid_i(pair.valid),
        .data_i (pair.even),
        .valid_o(odd_beat.valid),
        .sum_o  (odd_beat.sum)
    );

    decim_combiner u_combiner (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .en_i  (en_i),
        .even_i(even_beat),
        .odd_i (odd_beat),
        .out_o (out_o)
    );

endmodule

// ==== hw/shift_reg.sv ====
// Enable-gated delay line for a single strobe bit.
`timescale 1ns/100ps

module shift_reg #(
    parameter int DELAY = 6
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic en_i,
    input  logic data_i,
    output logic data_o
);

    logic [DELAY-1:0] stage_q;

    // The chain only moves on enabled cycles, so a held strobe
    // resumes in the same slot once the enable returns.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            stage_q <= '0;
        end else if (en_i) begin
            stage_q <= (stage_q << 1) | DELAY'(data_i);
        end
    end

    assign data_o = stage_q[DELAY-1] & en_i;

endmodule

// ==== test/poly_decim_stim.txt ====
# I en valid data count rnd : drive count cycles, rnd=1 takes data from $random
# R cycles : reset low ; E mode value sat count : 0 skip, 1 record value, 2 model
# Flush the delay lines with zeros.
I 1 1 0 28 0
E 0 0 0 14
# Impulse of 16384 followed by zeros.
I 1 1 16384 1 0
I 1 1 0 31 0
E 1 304 0 1
E 1 -177 0 1
E 1 269 0 1
E 1 -280 0 1
E 1 346 0 1
E 1 -355 0 1
E 1 370 0 1
E 1 -331 0 1
E 1 257 0 1
E 1 -99 0 1
E 1 -177 0 1
E 1 719 0 1
E 1 -2088 0 1
E 1 13969 0 1
E 1 0 0 2
# Random stream, back to back.
I 1 1 0 64 1
E 2 0 0 32
# Enable gaps mid-stream.
I 1 1 0 8 1
I 0 1 0 6 1
I 1 0 0 3 1
I 0 0 0 4 1
I 1 1 0 8 1
E 2 0 0 8
# Saturation at both limits, then small samples.
I 1 1 32767 40 0
E 2 0 0 14
E 1 32767 1 6
I 1 1 -32768 40 0
E 2 0 0 14
E 1 -32768 1 6
I 1 1 100 40 0
E 2 0 0 14
E 1 103 0 6
# Reset mid-stream after a zero flush, with an even sample pending.
I 1 1 0 28 0
E 2 0 0 14
I 1 1 0 4 0
I 1 1 20000 1 0
R 3
I 1 1 16384 1 0
I 1 1 0 1 0
E 1 304 0 1

// ==== test/tb_checks.svh ====
// Error counters and typed compare tasks for the decimating FIR testbench.
// One compare task per result kind, plus a task for non-value failures.
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors   = 0;
int latency_errors = 0;
int other_errors   = 0;

task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_sat(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) begin
        latency_errors++;
        $display("FAILED at %0t ns: %s got %0d cycles expected %0d", $time, name, got, exp);
    end
endtask

task automatic report_failure(input string msg);
    other_errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
endtask

`endif

// ==== test/tb_poly_decim.sv ====
// Testbench for the polyphase decimate-by-two FIR.
// Reads stimulus and expected records, keeps a y[m] reference model
// and checks every output pulse for value, saturation and latency.
`timescale 1ns/100ps
`include "fir_cfg.svh"

module tb_poly_decim import fir_pkg::*; ();

    localparam int TAPS    = `FIR_BRANCH_TAPS;
    localparam int TIMEOUT = 200;
    localparam int LATENCY = 8;

    logic      clk_i;
    logic      rstn_i;
    logic      en_i;
    logic      valid_i;
    sample_t   data_i;
    out_beat_t out_o;

    int seed = 32'h9a21_28de;
    int coef_even [TAPS] = `FIR_COEF_EVEN;
    int coef_odd  [TAPS] = `FIR_COEF_ODD;

    // Pair history of the reference model. Index 0 is the newest pair.
    int      even_hist [TAPS];
    int      odd_hist  [TAPS];
    sample_t pending_even;
    logic    phase;
    int      enabled_edges;
    logic    timed_out;

    sample_t exp_data_q [$];
    logic    exp_sat_q  [$];
    int      accept_q   [$];
    sample_t dut_data_q [$];
    logic    dut_sat_q  [$];
    int      dut_stamp_q [$];

    `include "tb_checks.svh"

    poly_decim_top UUT (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .en_i   (en_i),
        .valid_i(valid_i),
        .data_i (data_i),
        .out_o  (out_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Computes y[m] as the sum of h[k] * x[2m+1-k] with round half up and clamping.
    task automatic reference_output(output sample_t y, output logic sat);
        longint acc;
        acc = 0;
        for (int t = 0; t < TAPS; t++) begin
            acc += longint'(coef_even[t]) * odd_hist[t];
            acc += longint'(coef_odd[t]) * even_hist[t];
        end
        acc = (acc + (64'sd1 <<< (`FIR_ROUND_SHIFT - 1))) >>> `FIR_ROUND_SHIFT;
        sat = 1'b1;
        if (acc > 32767) begin
            y = 16'sh7fff;
        end else if (acc < -32768) begin
            y = 16'sh8000;
        end else begin
            y   = sample_t'(acc);
            sat = 1'b0;
        end
    endtask

    // Tracks accepted pairs and queues every output pulse.
    always @(posedge clk_i) begin : monitor
        sample_t y;
        logic    sat;
        if (!rstn_i) begin
            phase = 1'b0;
        end else if (en_i) begin
            enabled_edges++;
            if (out_o.valid) begin
                if (dut_data_q.size() >= exp_data_q.size()) begin
                    report_failure("output pulse with no pair pending");
                end else begin
                    dut_data_q.push_back(out_o.data);
                    dut_sat_q.push_back(out_o.sat);
                    dut_stamp_q.push_back(enabled_edges);
                end
            end
            if (valid_i) begin
                if (!phase) begin
                    pending_even = data_i;
                end else begin
                    for (int t = TAPS - 1; t > 0; t--) begin
                        even_hist[t] = even_hist[t-1];
                        odd_hist[t]  = odd_hist[t-1];
                    end
                    even_hist[0] = pending_even;
                    odd_hist[0]  = data_i;
                    reference_output(y, sat);
                    exp_data_q.push_back(y);
                    exp_sat_q.push_back(sat);
                    accept_q.push_back(enabled_edges);
                end
                phase = !phase;
            end
        end else if (out_o.valid) begin
            report_failure("output pulse while en_i is low");
        end
    end

    task automatic drive_cycle(input logic en, input logic valid, input sample_t data);
        @(posedge clk_i);
        en_i    <= en;
        valid_i <= valid;
        data_i  <= data;
    endtask

    task automatic drive_samples(input int en, input int valid, input int data,
                                 input int count, input int rnd);
        for (int i = 0; i < count; i++) begin
            if (rnd != 0) begin
                drive_cycle(en[0], valid[0], sample_t'($random(seed)));
            end else begin
                drive_cycle(en[0], valid[0], sample_t'(data));
            end
        end
    endtask

    // Pairs still in flight at reset never produce an output.
    task automatic apply_reset(input int cycles);
        @(posedge clk_i);
        rstn_i  <= 1'b0;
        valid_i <= 1'b0;
        repeat (cycles) @(posedge clk_i);
        rstn_i <= 1'b1;
        en_i   <= 1'b1;
        while (exp_data_q.size() > dut_data_q.size()) begin
            void'(exp_data_q.pop_back());
            void'(exp_sat_q.pop_back());
            void'(accept_q.pop_back());
        end
    endtask

    // Mode 0 skips the compare. Mode 1 uses the record's value and mode 2 the model.
    task automatic expect_outputs(input int mode, input int value, input int sat,
                                  input int count);
        int      waited;
        sample_t got;
        logic    got_sat;
        sample_t exp;
        logic    exp_sat;
        int      latency;
        for (int i = 0; i < count; i++) begin
            waited = 0;
            while (dut_data_q.size() == 0 && waited < TIMEOUT) begin
                drive_cycle(1'b1, 1'b0, sample_t'($random(seed)));
                waited++;
            end
            if (dut_data_q.size() == 0) begin
                report_failure("timed out waiting for an output pulse");
                timed_out = 1'b1;
                return;
            end
            got     = dut_data_q.pop_front();
            got_sat = dut_sat_q.pop_front();
            exp     = exp_data_q.pop_front();
            exp_sat = exp_sat_q.pop_front();
            latency = dut_stamp_q.pop_front() - accept_q.pop_front();
            if (mode == 1) begin
                exp     = sample_t'(value);
                exp_sat = sat[0];
            end
            if (mode != 0) begin
                check_sample("out_o.data", got, exp);
                check_sat("out_o.sat", got_sat, exp_sat);
                check_latency("out_o latency", latency, LATENCY);
            end
        end
    endtask

    initial begin : main
        int    fd;
        string line;
        byte   kind;
        int    f0;
        int    f1;
        int    f2;
        int    f3;
        int    f4;
        rstn_i        = 1'b0;
        en_i          = 1'b0;
        valid_i       = 1'b0;
        data_i        = '0;
        phase         = 1'b0;
        pending_even  = '0;
        enabled_edges = 0;
        timed_out     = 1'b0;
        for (int t = 0; t < TAPS; t++) begin
            even_hist[t] = 0;
            odd_hist[t]  = 0;
        end
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        en_i   <= 1'b1;

        fd = $fopen("test/poly_decim_stim.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open the stimulus file");
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    f0 = 0;
                    f1 = 0;
                    f2 = 0;
                    f3 = 0;
                    f4 = 0;
                    void'($sscanf(line, "%c %d %d %d %d %d", kind, f0, f1, f2, f3, f4));
                    case (kind)
                        "I": drive_samples(f0, f1, f2, f3, f4);
                        "R": apply_reset(f0);
                        "E": expect_outputs(f0, f1, f2, f3);
                        default: report_failure("unknown record in the stimulus file");
                    endcase
                end
            end
            $fclose(fd);
        end

        if (!timed_out) begin
            drive_samples(1, 0, 0, 20, 1);
            if (exp_data_q.size() != 0) begin
                report_failure("output pulses left without an expected record");
            end
        end

        $display("Errors: value %0d, latency %0d, other %0d",
                 value_errors, latency_errors, other_errors);
        if (value_errors == 0 && latency_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
